//--- Makefile
# Verilator flow for the L1 instruction cache
# Override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TB_TOP    ?= tb_l1i_top
DUT_TOP   ?= l1i_top
FLIST     ?= flist.f
BUILD_DIR ?= ./obj_dir
TIMESCALE ?= 1ns/1ps
VFLAGS    ?= --timing --assert --timescale $(TIMESCALE)
PASS_MSG  ?= TEST PASS
SIM_BIN   = $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

# Lint the design alone, then together with the testbench
lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(DUT_TOP)
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FLIST) --top-module $(TB_TOP) -Mdir $(BUILD_DIR)

# Pass only if the pass message shows up as a line of its own
sim: build
	@out="$$($(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

//--- flist.f
l1i_pkg.sv
l1i_tag_array.sv
l1i_data_array.sv
l1i_lru.sv
l1i_miss_ctrl.sv
l1i_top.sv
tb_l1i_mem.sv
tb_l1i_top.sv

//--- l1i_data_array.sv
// --------------------------------------------------
// Line storage for every way of the cache.
// Combinational read at raddr; a write replaces the
// whole line in the enabled way.
// --------------------------------------------------
module l1i_data_array #(
	parameter int WAY_NUM = 4,
	parameter int IDX_WIDTH = 4,
	parameter int OFFSET_WIDTH = 4,
	localparam int LINE_WIDTH = 8 << OFFSET_WIDTH
) (
	input  logic                  clk,
	input  logic [IDX_WIDTH-1:0]  raddr,
	input  logic [WAY_NUM-1:0]    wen,
	input  logic [IDX_WIDTH-1:0]  waddr,
	input  logic [LINE_WIDTH-1:0] wdata,
	output logic [LINE_WIDTH-1:0] rdata [WAY_NUM]
);

	localparam int SET_NUM = 1 << IDX_WIDTH;

	for (genvar way = 0; way < WAY_NUM; way++) begin : g_way
		logic [LINE_WIDTH-1:0] line_r [SET_NUM];

		// Full line only, no byte enables
		always_ff @(posedge clk) begin
			if (wen[way]) begin
				line_r[waddr] <= wdata;
			end
		end

		assign rdata[way] = line_r[raddr];
	end

	// Refill lands in exactly one way
	wen_onehot_a: assert property (@(posedge clk) $onehot0(wen))
		else $error("data array written in more than one way");

endmodule

//--- l1i_lru.sv
// --------------------------------------------------
// True LRU per set, hit detection and victim choice.
// Ages update on the first cycle of each request for
// the way that was hit or picked as victim.
// --------------------------------------------------
module l1i_lru #(
	parameter int WAY_NUM = 4,
	parameter int IDX_WIDTH = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 req,
	input  logic [IDX_WIDTH-1:0] idx,
	input  logic [WAY_NUM-1:0]   tag_cmp_vect,
	input  logic [WAY_NUM-1:0]   val_vect,
	output logic                 hit,
	output logic                 evict_val,
	output logic [WAY_NUM-1:0]   way_vect
);

	localparam int SET_NUM = 1 << IDX_WIDTH;
	localparam int WAY_W = (WAY_NUM > 1) ? $clog2(WAY_NUM) : 1;

	// Rank 0 is youngest, WAY_NUM-1 is oldest
	logic [WAY_W-1:0]   rank_r [SET_NUM][WAY_NUM];

	logic [WAY_NUM-1:0] hit_vect;
	logic [WAY_NUM-1:0] inv_vect;
	logic [WAY_NUM-1:0] lowest_inv;
	logic [WAY_NUM-1:0] oldest_vect;
	logic [WAY_W-1:0]   sel_rank;

	// --------------------------------------------------
	// Hit and victim
	// --------------------------------------------------
	assign hit_vect = tag_cmp_vect & val_vect;
	assign hit      = |hit_vect;
	assign inv_vect = ~val_vect;

	// Isolate lowest invalid way
	assign lowest_inv = inv_vect & (~inv_vect + 1'b1);

	for (genvar way = 0; way < WAY_NUM; way++) begin : g_old
		assign oldest_vect[way] = (rank_r[idx][way] == WAY_W'(WAY_NUM - 1));
	end

	// Invalid way wins over the oldest one
	assign way_vect  = hit ? hit_vect : ((|inv_vect) ? lowest_inv : oldest_vect);
	assign evict_val = ~hit & ~(|inv_vect);

	// Current rank of the touched way
	always_comb begin
		sel_rank = '0;
		for (int i = 0; i < WAY_NUM; i++) begin
			if (way_vect[i]) begin
				sel_rank = sel_rank | rank_r[idx][i];
			end
		end
	end

	// --------------------------------------------------
	// Age update
	// --------------------------------------------------
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int s = 0; s < SET_NUM; s++) begin
				for (int w = 0; w < WAY_NUM; w++) begin
					rank_r[s][w] <= WAY_W'(w);
				end
			end
		end else if (req) begin
			for (int w = 0; w < WAY_NUM; w++) begin
				if (way_vect[w]) begin
					rank_r[idx][w] <= '0;
				end else if (rank_r[idx][w] < sel_rank) begin
					// Younger than touched way, one step older
					rank_r[idx][w] <= rank_r[idx][w] + 1'b1;
				end
			end
		end
	end

	// A line sits in one way at most, given the tag array contents
	hit_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
		req |-> $onehot0(hit_vect))
		else $error("line present in more than one way");

	way_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
		req |-> $onehot0(way_vect))
		else $error("way vector not one-hot");

endmodule

//--- l1i_miss_ctrl.sv
// --------------------------------------------------
// Miss sequencing on the MAU val/ack interface.
// Writes back a valid victim first, then reads the
// requested line; refill_done marks the read ack.
// --------------------------------------------------
module l1i_miss_ctrl import l1i_pkg::*; #(
	parameter int OFFSET_WIDTH = 4,
	localparam int LINE_WIDTH = 8 << OFFSET_WIDTH,
	localparam int LADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH
) (
	input  logic                   clk,
	input  logic                   rst_n,
	input  logic                   miss,
	input  logic                   evict_val,
	input  logic [LADDR_WIDTH-1:0] req_tag_idx,
	input  logic [LADDR_WIDTH-1:0] victim_addr,
	input  logic [LINE_WIDTH-1:0]  victim_line,
	input  logic                   mau_req_ack,
	output logic                   mau_req_val,
	output mau_cmd_e               mau_req_ev,
	output logic [ADDR_WIDTH-1:0]  mau_req_addr,
	output logic [LINE_WIDTH-1:0]  mau_req_ev_data,
	output logic                   refill_done
);

	miss_state_e            state_r;
	miss_state_e            state_next;

	// Victim copy, taken when the miss is first seen
	logic [LADDR_WIDTH-1:0] ev_addr_r;
	logic [LINE_WIDTH-1:0]  ev_line_r;

	logic [LADDR_WIDTH-1:0] line_addr;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_r <= MISS_IDLE;
		end else begin
			state_r <= state_next;
		end
	end

	always_ff @(posedge clk) begin
		if (state_r == MISS_IDLE && miss && evict_val) begin
			ev_addr_r <= victim_addr;
			ev_line_r <= victim_line;
		end
	end

	// --------------------------------------------------
	// Next state and MAU request
	// --------------------------------------------------
	always_comb begin
		state_next      = state_r;
		mau_req_val     = 1'b0;
		mau_req_ev      = MAU_READ;
		line_addr       = req_tag_idx;
		mau_req_ev_data = '0;
		refill_done     = 1'b0;
		case (state_r)
			MISS_IDLE: begin
				// Request goes out in the lookup cycle itself
				if (miss) begin
					mau_req_val = 1'b1;
					if (evict_val) begin
						mau_req_ev      = MAU_WRITEBACK;
						line_addr       = victim_addr;
						mau_req_ev_data = victim_line;
						state_next      = mau_req_ack ? MISS_REFILL : MISS_EVICT;
					end else begin
						// Zero-wait MAU finishes the refill here
						refill_done = mau_req_ack;
						state_next  = mau_req_ack ? MISS_IDLE : MISS_REFILL;
					end
				end
			end
			MISS_EVICT: begin
				mau_req_val     = 1'b1;
				mau_req_ev      = MAU_WRITEBACK;
				line_addr       = ev_addr_r;
				mau_req_ev_data = ev_line_r;
				if (mau_req_ack) begin
					state_next = MISS_REFILL;
				end
			end
			MISS_REFILL: begin
				mau_req_val = 1'b1;
				refill_done = mau_req_ack;
				if (mau_req_ack) begin
					state_next = MISS_IDLE;
				end
			end
			default: begin
				state_next = MISS_IDLE;
			end
		endcase
	end

	// Always line aligned
	assign mau_req_addr = {line_addr, {OFFSET_WIDTH{1'b0}}};

	// Holds only while the core keeps its address stable
	req_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
		mau_req_val && !mau_req_ack |=> mau_req_val && $stable(mau_req_ev)
			&& $stable(mau_req_addr) && $stable(mau_req_ev_data))
		else $error("MAU request changed before acknowledge");

endmodule

//--- l1i_pkg.sv
// --------------------------------------------------
// Shared widths and enums of the L1 instruction cache.
// Imported by the RTL modules and the testbench.
// --------------------------------------------------
package l1i_pkg;

	// --------------------------------------------------
	// Widths
	// --------------------------------------------------

	// Core and MAU byte address
	localparam int ADDR_WIDTH = 32;

	// Instruction word returned to the core
	localparam int DATA_WIDTH = 32;

	// --------------------------------------------------
	// Miss controller
	// --------------------------------------------------

	// Idle covers the lookup cycle, both on hits and on
	// the first cycle of a miss
	typedef enum logic [1:0] {
		MISS_IDLE   = 2'b00,
		// Write-back of a valid victim pending
		MISS_EVICT  = 2'b01,
		// Line read pending
		MISS_REFILL = 2'b10
	} miss_state_e;

	// --------------------------------------------------
	// MAU command
	// --------------------------------------------------

	// Drives the mau_req_ev line
	typedef enum logic {
		MAU_READ      = 1'b0,
		MAU_WRITEBACK = 1'b1
	} mau_cmd_e;

endpackage

//--- l1i_tag_array.sv
// --------------------------------------------------
// Valid bits and tags for every way of the cache.
// Combinational read at raddr, synchronous write of
// the enabled ways; valid bits clear on reset.
// --------------------------------------------------
module l1i_tag_array import l1i_pkg::*; #(
	parameter int WAY_NUM = 4,
	parameter int IDX_WIDTH = 4,
	parameter int OFFSET_WIDTH = 4,
	localparam int TAG_WIDTH = ADDR_WIDTH - IDX_WIDTH - OFFSET_WIDTH
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [IDX_WIDTH-1:0] raddr,
	input  logic [WAY_NUM-1:0]   wen,
	input  logic [IDX_WIDTH-1:0] waddr,
	input  logic [TAG_WIDTH-1:0] wtag,
	output logic [WAY_NUM-1:0]   rd_val,
	output logic [TAG_WIDTH-1:0] rd_tag [WAY_NUM]
);

	localparam int SET_NUM = 1 << IDX_WIDTH;

	for (genvar way = 0; way < WAY_NUM; way++) begin : g_way
		logic [SET_NUM-1:0]   val_r;
		logic [TAG_WIDTH-1:0] tag_r [SET_NUM];

		// Valid bits, one per set
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				val_r <= '0;
			end else if (wen[way]) begin
				val_r[waddr] <= 1'b1;
			end
		end

		// Tag storage, meaningless until valid
		always_ff @(posedge clk) begin
			if (wen[way]) begin
				tag_r[waddr] <= wtag;
			end
		end

		assign rd_val[way] = val_r[raddr];
		assign rd_tag[way] = tag_r[raddr];
	end

endmodule

//--- l1i_top.sv
// --------------------------------------------------
// L1 instruction cache top level.
// Lookup stage, tag and data arrays, LRU, miss
// controller and word return to the core.
// --------------------------------------------------
module l1i_top import l1i_pkg::*; #(
	parameter int WAY_NUM = 4,
	parameter int IDX_WIDTH = 4,
	parameter int OFFSET_WIDTH = 4,
	localparam int LINE_WIDTH = 8 << OFFSET_WIDTH
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  core_req_val,
	input  logic [ADDR_WIDTH-1:0] core_req_addr,
	output logic                  core_req_ack,
	output logic [DATA_WIDTH-1:0] core_ack_data,
	output logic                  mau_req_val,
	output mau_cmd_e              mau_req_ev,
	output logic [ADDR_WIDTH-1:0] mau_req_addr,
	output logic [LINE_WIDTH-1:0] mau_req_ev_data,
	input  logic                  mau_req_ack,
	input  logic [LINE_WIDTH-1:0] mau_ack_data
);

	localparam int TAG_WIDTH = ADDR_WIDTH - IDX_WIDTH - OFFSET_WIDTH;
	localparam int WAY_W = (WAY_NUM > 1) ? $clog2(WAY_NUM) : 1;
	localparam int BYTE_SEL = $clog2(DATA_WIDTH / 8);

	logic [TAG_WIDTH-1:0]    req_tag;
	logic [IDX_WIDTH-1:0]    req_idx;
	logic [OFFSET_WIDTH-1:0] req_offset;
	logic [OFFSET_WIDTH-BYTE_SEL-1:0] word_sel;

	// Request already seen in an earlier cycle
	logic                    held_r;
	logic                    lru_req;
	logic                    miss;
	logic                    refill_done;

	logic                    lru_hit;
	logic                    lru_evict_val;
	logic [WAY_NUM-1:0]      lru_way_vect;
	logic [WAY_NUM-1:0]      way_vect_r;
	logic [WAY_NUM-1:0]      way_sel;
	logic [WAY_W-1:0]        way_num;

	logic [WAY_NUM-1:0]      tag_cmp_vect;
	logic [WAY_NUM-1:0]      tag_rd_val;
	logic [TAG_WIDTH-1:0]    tag_rd_tag [WAY_NUM];
	logic [LINE_WIDTH-1:0]   data_rdata [WAY_NUM];
	logic [WAY_NUM-1:0]      arr_wen;
	logic [LINE_WIDTH-1:0]   core_line;

	function automatic logic [WAY_W-1:0] onehot_to_num(input logic [WAY_NUM-1:0] vect);
		logic [WAY_W-1:0] num;
		num = '0;
		for (int i = 0; i < WAY_NUM; i++) begin
			if (vect[i]) begin
				num = num | WAY_W'(i);
			end
		end
		return num;
	endfunction

	// --------------------------------------------------
	// Lookup stage
	// --------------------------------------------------
	assign {req_tag, req_idx, req_offset} = core_req_addr;
	assign word_sel = req_offset[OFFSET_WIDTH-1:BYTE_SEL];

	for (genvar way = 0; way < WAY_NUM; way++) begin : g_cmp
		assign tag_cmp_vect[way] = (tag_rd_tag[way] == req_tag);
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			held_r <= 1'b0;
		end else begin
			held_r <= core_req_val & ~core_req_ack;
		end
	end

	assign lru_req = core_req_val & ~held_r;
	assign miss    = lru_req & ~lru_hit;

	// LRU moves on after the first cycle, keep its choice
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			way_vect_r <= '0;
		end else if (lru_req) begin
			way_vect_r <= lru_way_vect;
		end
	end

	assign way_sel = held_r ? way_vect_r : lru_way_vect;
	assign way_num = onehot_to_num(way_sel);

	// --------------------------------------------------
	// Array writes on refill
	// --------------------------------------------------
	assign arr_wen = way_sel & {WAY_NUM{refill_done}};

	l1i_tag_array #(
		.WAY_NUM      (WAY_NUM),
		.IDX_WIDTH    (IDX_WIDTH),
		.OFFSET_WIDTH (OFFSET_WIDTH)
	) u_tag_array (
		.clk    (clk),
		.rst_n  (rst_n),
		.raddr  (req_idx),
		.wen    (arr_wen),
		.waddr  (req_idx),
		.wtag   (req_tag),
		.rd_val (tag_rd_val),
		.rd_tag (tag_rd_tag)
	);

	l1i_data_array #(
		.WAY_NUM      (WAY_NUM),
		.IDX_WIDTH    (IDX_WIDTH),
		.OFFSET_WIDTH (OFFSET_WIDTH)
	) u_data_array (
		.clk   (clk),
		.raddr (req_idx),
		.wen   (arr_wen),
		.waddr (req_idx),
		.wdata (mau_ack_data),
		.rdata (data_rdata)
	);

	l1i_lru #(
		.WAY_NUM   (WAY_NUM),
		.IDX_WIDTH (IDX_WIDTH)
	) u_lru (
		.clk          (clk),
		.rst_n        (rst_n),
		.req          (lru_req),
		.idx          (req_idx),
		.tag_cmp_vect (tag_cmp_vect),
		.val_vect     (tag_rd_val),
		.hit          (lru_hit),
		.evict_val    (lru_evict_val),
		.way_vect     (lru_way_vect)
	);

	// Victim fields only matter in the lookup cycle
	l1i_miss_ctrl #(
		.OFFSET_WIDTH (OFFSET_WIDTH)
	) u_miss_ctrl (
		.clk             (clk),
		.rst_n           (rst_n),
		.miss            (miss),
		.evict_val       (lru_evict_val),
		.req_tag_idx     ({req_tag, req_idx}),
		.victim_addr     ({tag_rd_tag[way_num], req_idx}),
		.victim_line     (data_rdata[way_num]),
		.mau_req_ack     (mau_req_ack),
		.mau_req_val     (mau_req_val),
		.mau_req_ev      (mau_req_ev),
		.mau_req_addr    (mau_req_addr),
		.mau_req_ev_data (mau_req_ev_data),
		.refill_done     (refill_done)
	);

	// --------------------------------------------------
	// Word return
	// --------------------------------------------------

	// Hit acks at once, a miss acks with the refill read
	assign core_req_ack  = (lru_req & lru_hit) | refill_done;
	assign core_line     = lru_hit ? data_rdata[way_num] : mau_ack_data;
	assign core_ack_data = core_line[word_sel*DATA_WIDTH +: DATA_WIDTH];

	addr_align_a: assert property (@(posedge clk) disable iff (!rst_n)
		core_req_val |-> req_offset[BYTE_SEL-1:0] == '0)
		else $error("fetch address not word aligned");

endmodule

//--- tb_l1i_mem.sv
// --------------------------------------------------
// MAU model for the cache testbench.
// Answers line reads from a fixed address rule, acks
// after a random delay and logs each write-back.
// --------------------------------------------------
module tb_l1i_mem import l1i_pkg::*; #(
	parameter int OFFSET_WIDTH = 4,
	parameter logic [31:0] PATTERN = 32'h5a3c96e1,
	parameter logic [31:0] SEED = 32'h1,
	localparam int LINE_WIDTH = 8 << OFFSET_WIDTH
) (
	input  logic                  clk,
	input  int                    max_delay,
	input  logic                  mau_req_val,
	input  mau_cmd_e              mau_req_ev,
	input  logic [ADDR_WIDTH-1:0] mau_req_addr,
	input  logic [LINE_WIDTH-1:0] mau_req_ev_data,
	output logic                  mau_req_ack,
	output logic [LINE_WIDTH-1:0] mau_ack_data,
	output int                    wb_count,
	output logic [ADDR_WIDTH-1:0] last_wb_addr,
	output logic [LINE_WIDTH-1:0] last_wb_line
);
	timeunit 1ns;
	timeprecision 100ps;

	integer                seed = SEED;
	// Request seen and not yet acknowledged
	logic                  waiting = 1'b0;
	int                    delay_left = 0;
	logic [ADDR_WIDTH-1:0] cur_addr = '0;

	// Each word is its byte address mixed with the pattern
	function automatic logic [LINE_WIDTH-1:0] rule_line(input logic [ADDR_WIDTH-1:0] base);
		logic [LINE_WIDTH-1:0] line;
		for (int i = 0; i < LINE_WIDTH / DATA_WIDTH; i++) begin
			line[i*DATA_WIDTH +: DATA_WIDTH] = (base + ADDR_WIDTH'(4 * i)) ^ PATTERN;
		end
		return line;
	endfunction

	initial begin
		mau_req_ack = 1'b0;
		mau_ack_data = '0;
		wb_count = 0;
		last_wb_addr = '0;
		last_wb_line = '0;
	end

	// Drive on the falling edge, look 1 ns later once settled
	always @(negedge clk) begin
		mau_req_ack <= waiting && delay_left == 0;
		mau_ack_data <= rule_line(cur_addr);
		#1;
		if (mau_req_val && mau_req_ack) begin
			// Transfer completes on the coming rising edge
			if (mau_req_ev == MAU_WRITEBACK) begin
				wb_count = wb_count + 1;
				last_wb_addr = mau_req_addr;
				last_wb_line = mau_req_ev_data;
			end
			waiting = 1'b0;
		end else if (mau_req_val && !waiting) begin
			waiting = 1'b1;
			cur_addr = mau_req_addr;
			delay_left = $unsigned($random(seed)) % (max_delay + 1);
		end else if (waiting && delay_left > 0) begin
			delay_left = delay_left - 1;
		end
	end

endmodule

//--- tb_l1i_top.sv
// --------------------------------------------------
// Directed tests for the L1 instruction cache.
// A reference model of tags, valid bits and LRU ranks
// predicts every hit, victim and write-back.
// --------------------------------------------------
module tb_l1i_top import l1i_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int WAY_NUM = 4;
	localparam int IDX_WIDTH = 4;
	localparam int OFFSET_WIDTH = 4;
	localparam int SET_NUM = 1 << IDX_WIDTH;
	localparam int TAG_WIDTH = ADDR_WIDTH - IDX_WIDTH - OFFSET_WIDTH;
	localparam int LINE_WIDTH = 8 << OFFSET_WIDTH;
	localparam logic [31:0] PATTERN = 32'h5a3c96e1;
	localparam logic [31:0] SEED = 32'hd361670f;

	// Worst miss is write-back plus read, each up to 5 cycles
	localparam int NUM_FETCH = 72;
	localparam int MISS_CYCLES = 10;
	localparam int TIMEOUT_CYCLES = NUM_FETCH * MISS_CYCLES + 100;

	logic                  clk;
	logic                  rst_n;
	logic                  core_req_val;
	logic [ADDR_WIDTH-1:0] core_req_addr;
	logic                  core_req_ack;
	logic [DATA_WIDTH-1:0] core_ack_data;
	logic                  mau_req_val;
	mau_cmd_e              mau_req_ev;
	logic [ADDR_WIDTH-1:0] mau_req_addr;
	logic [LINE_WIDTH-1:0] mau_req_ev_data;
	logic                  mau_req_ack;
	logic [LINE_WIDTH-1:0] mau_ack_data;
	int                    max_delay;
	int                    wb_count;
	logic [ADDR_WIDTH-1:0] last_wb_addr;
	logic [LINE_WIDTH-1:0] last_wb_line;

	// Reference model, rank 0 youngest
	logic                  model_val [SET_NUM][WAY_NUM];
	logic [TAG_WIDTH-1:0]  model_tag [SET_NUM][WAY_NUM];
	int                    model_rank [SET_NUM][WAY_NUM];
	integer                seed = SEED;
	int                    cycles = 0;

	l1i_top #(
		.WAY_NUM      (WAY_NUM),
		.IDX_WIDTH    (IDX_WIDTH),
		.OFFSET_WIDTH (OFFSET_WIDTH)
	) dut (
		.clk             (clk),
		.rst_n           (rst_n),
		.core_req_val    (core_req_val),
		.core_req_addr   (core_req_addr),
		.core_req_ack    (core_req_ack),
		.core_ack_data   (core_ack_data),
		.mau_req_val     (mau_req_val),
		.mau_req_ev      (mau_req_ev),
		.mau_req_addr    (mau_req_addr),
		.mau_req_ev_data (mau_req_ev_data),
		.mau_req_ack     (mau_req_ack),
		.mau_ack_data    (mau_ack_data)
	);

	tb_l1i_mem #(
		.OFFSET_WIDTH (OFFSET_WIDTH),
		.PATTERN      (PATTERN),
		.SEED         (SEED)
	) mem (
		.clk             (clk),
		.max_delay       (max_delay),
		.mau_req_val     (mau_req_val),
		.mau_req_ev      (mau_req_ev),
		.mau_req_addr    (mau_req_addr),
		.mau_req_ev_data (mau_req_ev_data),
		.mau_req_ack     (mau_req_ack),
		.mau_ack_data    (mau_ack_data),
		.wb_count        (wb_count),
		.last_wb_addr    (last_wb_addr),
		.last_wb_line    (last_wb_line)
	);

	initial clk = 1'b0;
	always #2 clk = ~clk;

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("Timeout after %0d cycles, a fetch was never acknowledged", cycles);
			$display("TEST FAIL");
			$fatal(1, "simulation stopped");
		end
	end

	// --------------------------------------------------
	// Checks
	// --------------------------------------------------
	task automatic stop_run(input string what);
		$display("%s", what);
		$display("TEST FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_flag(input string name, input logic got, exp);
		if (got !== exp) begin
			stop_run($sformatf("CHECK FAILED at %0d ns: %s = %b, expected %b", $time, name, got, exp));
		end
	endtask

	task automatic check_word(input string name, input logic [DATA_WIDTH-1:0] got, exp);
		if (got !== exp) begin
			stop_run($sformatf("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_addr(input string name, input logic [ADDR_WIDTH-1:0] got, exp);
		if (got !== exp) begin
			stop_run($sformatf("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp));
		end
	endtask

	task automatic check_cmd(input string name, input mau_cmd_e got, exp);
		if (got !== exp) begin
			stop_run($sformatf("CHECK FAILED at %0d ns: %s = %s, expected %s", $time, name,
				got.name(), exp.name()));
		end
	endtask

	task automatic check_line(input string name, input logic [LINE_WIDTH-1:0] got, exp);
		if (got !== exp) begin
			stop_run($sformatf("CHECK FAILED at %0d ns: %s = %h, expected %h", $time, name, got, exp));
		end
	endtask

	// --------------------------------------------------
	// Address rule and reference model
	// --------------------------------------------------
	function automatic logic [ADDR_WIDTH-1:0] make_addr(input logic [TAG_WIDTH-1:0] tag,
		input int idx, input int word);
		return {tag, IDX_WIDTH'(idx), OFFSET_WIDTH'(word * 4)};
	endfunction

	function automatic logic [LINE_WIDTH-1:0] expect_line(input logic [ADDR_WIDTH-1:0] base);
		logic [LINE_WIDTH-1:0] line;
		for (int i = 0; i < LINE_WIDTH / DATA_WIDTH; i++) begin
			line[i*DATA_WIDTH +: DATA_WIDTH] = (base + ADDR_WIDTH'(4 * i)) ^ PATTERN;
		end
		return line;
	endfunction

	// One fetch, checked cycle by cycle against the model
	task automatic fetch(input logic [ADDR_WIDTH-1:0] addr, output logic missed);
		logic [TAG_WIDTH-1:0]  tag;
		logic [ADDR_WIDTH-1:0] line_addr;
		logic [ADDR_WIDTH-1:0] wb_addr;
		int                    idx;
		int                    way;
		int                    sel;
		logic                  hit_exp;
		logic                  evict_exp;
		logic                  ack_exp;
		logic                  done;
		mau_cmd_e              phase;
		tag = addr[ADDR_WIDTH-1 -: TAG_WIDTH];
		idx = int'(addr[OFFSET_WIDTH +: IDX_WIDTH]);
		line_addr = {addr[ADDR_WIDTH-1:OFFSET_WIDTH], {OFFSET_WIDTH{1'b0}}};
		hit_exp = 1'b0;
		way = -1;
		for (int w = 0; w < WAY_NUM; w++) begin
			if (model_val[idx][w] && model_tag[idx][w] == tag) begin
				hit_exp = 1'b1;
				way = w;
			end
		end
		// Victim is the lowest invalid way, else the oldest
		if (!hit_exp) begin
			for (int w = WAY_NUM - 1; w >= 0; w--) begin
				if (!model_val[idx][w]) begin
					way = w;
				end
			end
			for (int w = 0; w < WAY_NUM; w++) begin
				if (way < 0 && model_rank[idx][w] == WAY_NUM - 1) begin
					way = w;
				end
			end
		end
		evict_exp = !hit_exp && model_val[idx][way];
		wb_addr = make_addr(model_tag[idx][way], idx, 0);
		// Touched way turns youngest
		sel = model_rank[idx][way];
		for (int w = 0; w < WAY_NUM; w++) begin
			if (w == way) begin
				model_rank[idx][w] = 0;
			end else if (model_rank[idx][w] < sel) begin
				model_rank[idx][w] = model_rank[idx][w] + 1;
			end
		end
		model_val[idx][way] = 1'b1;
		model_tag[idx][way] = tag;

		@(negedge clk);
		core_req_val = 1'b1;
		core_req_addr = addr;
		phase = evict_exp ? MAU_WRITEBACK : MAU_READ;
		missed = 1'b0;
		done = 1'b0;
		while (!done) begin
			#1;
			if (mau_req_val) begin
				missed = 1'b1;
				if (hit_exp) begin
					stop_run("MAU request raised for a fetch the model predicts as a hit");
				end
				check_cmd("mau_req_ev", mau_req_ev, phase);
				check_addr("mau_req_addr", mau_req_addr,
					(phase == MAU_WRITEBACK) ? wb_addr : line_addr);
				if (phase == MAU_WRITEBACK) begin
					check_line("mau_req_ev_data", mau_req_ev_data, expect_line(wb_addr));
				end
			end else if (!hit_exp) begin
				stop_run("MAU request missing while a miss is outstanding");
			end
			// Hit acks in its first cycle, a miss with the read ack
			ack_exp = hit_exp || (mau_req_ack && phase == MAU_READ);
			check_flag("core_req_ack", core_req_ack, ack_exp);
			if (core_req_ack) begin
				check_word("core_ack_data", core_ack_data, addr ^ PATTERN);
				done = 1'b1;
			end
			if (mau_req_val && mau_req_ack) begin
				phase = MAU_READ;
			end
			@(posedge clk);
			if (!done) begin
				@(negedge clk);
			end
		end
	endtask

	// --------------------------------------------------
	// Tests
	// --------------------------------------------------
	task automatic cold_miss_then_hit();
		logic missed;
		fetch(make_addr(TAG_WIDTH'(24'h000123), 3, 1), missed);
		if (!missed) begin
			stop_run("first fetch after reset never reached the MAU");
		end
		fetch(make_addr(TAG_WIDTH'(24'h000123), 3, 2), missed);
	endtask

	task automatic word_select();
		logic missed;
		for (int w = 0; w < 4; w++) begin
			fetch(make_addr(TAG_WIDTH'(24'h000123), 3, w), missed);
		end
	endtask

	task automatic fill_order();
		logic missed;
		int   wb_before;
		wb_before = wb_count;
		for (int t = 0; t < WAY_NUM; t++) begin
			fetch(make_addr(TAG_WIDTH'(16 + t), 5, t), missed);
		end
		if (wb_count != wb_before) begin
			stop_run("write-back issued while filling an empty set");
		end
	endtask

	task automatic lru_eviction();
		int   order [WAY_NUM] = '{1, 3, 0, 2};
		logic missed;
		int   wb_before;
		// Tag 0x11 ends up least recently used
		for (int i = 0; i < WAY_NUM; i++) begin
			fetch(make_addr(TAG_WIDTH'(16 + order[i]), 5, i), missed);
		end
		wb_before = wb_count;
		fetch(make_addr(TAG_WIDTH'(24'h14), 5, 0), missed);
		if (wb_count != wb_before + 1) begin
			stop_run("miss in a full set did not write back exactly one line");
		end
		check_addr("last_wb_addr", last_wb_addr, make_addr(TAG_WIDTH'(24'h11), 5, 0));
		check_line("last_wb_line", last_wb_line,
			expect_line(make_addr(TAG_WIDTH'(24'h11), 5, 0)));
		fetch(make_addr(TAG_WIDTH'(24'h11), 5, 3), missed);
		if (!missed) begin
			stop_run("evicted line still hit after its eviction");
		end
	endtask

	task automatic back_pressure();
		logic missed;
		int   idx;
		int   tag;
		int   word;
		max_delay = 3;
		// Six tags over four ways keep evictions coming
		for (int i = 0; i < 40; i++) begin
			idx = $unsigned($random(seed)) % 4;
			tag = $unsigned($random(seed)) % 6;
			word = $unsigned($random(seed)) % 4;
			fetch(make_addr(TAG_WIDTH'(64 + tag), idx, word), missed);
		end
	endtask

	task automatic set_isolation();
		logic missed;
		for (int t = 0; t < WAY_NUM; t++) begin
			fetch(make_addr(TAG_WIDTH'(32 + t), 8, 0), missed);
		end
		// Twice the ways in the neighbouring set
		for (int t = 0; t < 2 * WAY_NUM; t++) begin
			fetch(make_addr(TAG_WIDTH'(48 + t), 9, t % 4), missed);
		end
		for (int t = 0; t < WAY_NUM; t++) begin
			fetch(make_addr(TAG_WIDTH'(32 + t), 8, 1), missed);
			if (missed) begin
				stop_run("line in set 8 was lost to traffic in set 9");
			end
		end
	endtask

	initial begin
		rst_n = 1'b0;
		core_req_val = 1'b0;
		core_req_addr = '0;
		max_delay = 0;
		for (int s = 0; s < SET_NUM; s++) begin
			for (int w = 0; w < WAY_NUM; w++) begin
				model_val[s][w] = 1'b0;
				model_tag[s][w] = '0;
				model_rank[s][w] = w;
			end
		end
		repeat (3) @(negedge clk);
		rst_n = 1'b1;
		cold_miss_then_hit();
		word_select();
		fill_order();
		lru_eviction();
		back_pressure();
		set_isolation();
		@(negedge clk);
		core_req_val = 1'b0;
		@(negedge clk);
		$display("TEST PASS");
		$finish;
	end

endmodule
